/* source/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	typedef logic [15:0] dataWord;
	typedef logic [3:0] regIndex;

	// Implied operands of the U8 modes
	localparam regIndex regA = 4'd10;
	localparam regIndex regB = 4'd11;

	parameter dataWord resetVector = 16'h0000;

	typedef enum logic [3:0] {
		ALU_MOV = 4'd0,
		ALU_ADD = 4'd1,
		ALU_SUB = 4'd2,
		ALU_AND = 4'd3,
		ALU_OR  = 4'd4,
		ALU_XOR = 4'd5,
		ALU_SL  = 4'd6,
		ALU_SR  = 4'd7,
		ALU_SRA = 4'd8,
		ALU_ROT = 4'd9
	} aluOp;

	typedef enum logic [1:0] {
		REG_REG   = 2'd0,
		REG_U4    = 2'd1,
		REGB_U8   = 2'd2,
		REGA_U8RB = 2'd3
	} aluMode;

	// Code 3 is unused and decodes as NOP
	typedef enum logic [1:0] {
		MEM_LD  = 2'd0,
		MEM_LDB = 2'd1,
		MEM_ST  = 2'd2
	} memOp;

	typedef enum logic [1:0] {
		COND_ALWAYS = 2'd0,
		COND_Z      = 2'd1,
		COND_C      = 2'd2,
		COND_S      = 2'd3
	} condSel;

	typedef enum logic [1:0] {
		FETCH   = 2'd0,
		DECODE  = 2'd1,
		EXECUTE = 2'd2,
		COMMIT  = 2'd3
	} phase;

	// Instruction bits 15:14
	typedef enum logic [1:0] {
		SYSTEM = 2'd0,
		ALU    = 2'd1,
		LDST   = 2'd2,
		JUMP   = 2'd3
	} instrGroup;

	typedef struct packed {
		logic z;
		logic c;
		logic s;
	} flagSet;

	typedef struct packed {
		instrGroup group;
		aluOp      op;
		aluMode    mode;
		memOp      mem;
		condSel    cond;
		logic      sense;
		logic      relative;
		regIndex   rd;
		regIndex   rs;
		dataWord   imm;
		logic      regWrite;
	} ctrlWord;

endpackage

`default_nettype wire

/* source/phaseSequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module phaseSequencer #(
	parameter cpuPkg::dataWord PcStep = 16'd2
) (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire cpuPkg::dataWord din,
	input  wire cpuPkg::dataWord nextPc,
	output cpuPkg::phase         curPhase,
	output cpuPkg::dataWord      pc,
	output cpuPkg::dataWord      instr
);

	import cpuPkg::*;

	// Instructions sit on PcStep boundaries, so the low offset bits are dropped
	localparam dataWord alignMask = ~(PcStep - 16'd1);

	always_ff @(posedge clk) begin
		if (rst) begin
			curPhase <= FETCH;
			pc <= resetVector;
		end else begin
			case (curPhase)
				FETCH:   curPhase <= DECODE;
				DECODE:  curPhase <= EXECUTE;
				EXECUTE: curPhase <= COMMIT;
				default: begin
					curPhase <= FETCH;
					pc <= nextPc & alignMask;
				end
			endcase
		end
	end

	// Instruction word arrives on din during fetch
	always_ff @(posedge clk) begin
		if (curPhase == FETCH) begin
			instr <= din;
		end
	end

endmodule

`default_nettype wire

/* source/instrDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

module instrDecoder (
	input  wire cpuPkg::dataWord instr,
	output cpuPkg::ctrlWord      ctrl
);

	import cpuPkg::*;

	always_comb begin
		ctrl = '0;
		ctrl.group = instrGroup'(instr[15:14]);
		case (ctrl.group)
			ALU: begin
				ctrl.op = aluOp'(instr[13:10]);
				ctrl.mode = aluMode'(instr[9:8]);
				ctrl.regWrite = 1'b1;
				case (ctrl.mode)
					REG_REG: begin
						ctrl.rd = instr[7:4];
						ctrl.rs = instr[3:0];
					end
					REG_U4: begin
						ctrl.rd = instr[7:4];
						ctrl.rs = instr[3:0];
						ctrl.imm = {12'h000, instr[3:0]};
					end
					REGB_U8: begin
						ctrl.rd = regB;
						ctrl.rs = regB;
						ctrl.imm = {8'h00, instr[7:0]};
					end
					default: begin
						// RB supplies the low byte inside the ALU
						ctrl.rd = regA;
						ctrl.rs = regB;
						ctrl.imm = {instr[7:0], 8'h00};
					end
				endcase
				// Op codes past ROT are NOPs
				if (instr[13:10] > ALU_ROT) begin
					ctrl = '0;
				end
			end
			LDST: begin
				ctrl.mem = memOp'(instr[13:12]);
				ctrl.rd = instr[7:4];
				ctrl.rs = instr[3:0];
				ctrl.regWrite = (ctrl.mem != MEM_ST);
				if (instr[13:12] == 2'b11) begin
					ctrl = '0;
				end
			end
			JUMP: begin
				ctrl.sense = instr[13];
				ctrl.cond = condSel'(instr[12:11]);
				ctrl.relative = instr[8];
				ctrl.rs = instr[3:0];
				// Signed byte offset
				ctrl.imm = {{8{instr[7]}}, instr[7:0]};
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* source/regFile.sv */
`timescale 1ns/100ps
`default_nettype none

module regFile (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire cpuPkg::regIndex readIdxA,
	input  wire cpuPkg::regIndex readIdxB,
	input  wire logic            writeEnable,
	input  wire cpuPkg::regIndex writeIdx,
	input  wire cpuPkg::dataWord writeData,
	output cpuPkg::dataWord      readA,
	output cpuPkg::dataWord      readB
);

	import cpuPkg::*;

	dataWord regs [16];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeIdx] <= writeData;
		end
	end

	assign readA = regs[readIdxA];
	assign readB = regs[readIdxB];

endmodule

`default_nettype wire

/* source/aluUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module aluUnit (
	input  wire cpuPkg::ctrlWord ctrl,
	input  wire cpuPkg::dataWord opA,
	input  wire cpuPkg::dataWord opB,
	output cpuPkg::dataWord      result,
	output cpuPkg::flagSet       flags
);

	import cpuPkg::*;

	dataWord     operand;
	logic        carry;
	logic [31:0] rotPair;

	// Second operand by source mode
	always_comb begin
		case (ctrl.mode)
			REG_REG:   operand = opB;
			REGA_U8RB: operand = {ctrl.imm[15:8], opB[7:0]};
			default:   operand = ctrl.imm;
		endcase
	end

	// Rotate right as a shift of the doubled word
	assign rotPair = {opA, opA} >> operand[3:0];

	always_comb begin
		carry = 1'b0;
		case (ctrl.op)
			ALU_MOV: result = operand;
			ALU_ADD: {carry, result} = {1'b0, opA} + {1'b0, operand};
			// Carry holds the borrow
			ALU_SUB: {carry, result} = {1'b0, opA} - {1'b0, operand};
			ALU_AND: result = opA & operand;
			ALU_OR:  result = opA | operand;
			ALU_XOR: result = opA ^ operand;
			ALU_SL:  result = opA << operand[3:0];
			ALU_SR:  result = opA >> operand[3:0];
			ALU_SRA: result = dataWord'($signed(opA) >>> operand[3:0]);
			ALU_ROT: result = rotPair[15:0];
			default: result = operand;
		endcase
	end

	assign flags.z = (result == 16'h0000);
	assign flags.c = carry;
	assign flags.s = result[15];

endmodule

`default_nettype wire

/* source/branchUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module branchUnit #(
	parameter cpuPkg::dataWord PcStep = 16'd2
) (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire cpuPkg::phase    curPhase,
	input  wire cpuPkg::ctrlWord ctrl,
	input  wire cpuPkg::flagSet  aluFlags,
	input  wire cpuPkg::dataWord pc,
	input  wire cpuPkg::dataWord regValue,
	output cpuPkg::dataWord      nextPc
);

	import cpuPkg::*;

	flagSet  flags;
	logic    condTrue;
	logic    taken;
	dataWord seqPc;
	dataWord target;

	// Only ALU instructions touch the flags
	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
		end else if (curPhase == COMMIT && ctrl.group == ALU) begin
			flags <= aluFlags;
		end
	end

	always_comb begin
		case (ctrl.cond)
			COND_Z:  condTrue = flags.z;
			COND_C:  condTrue = flags.c;
			COND_S:  condTrue = flags.s;
			default: condTrue = 1'b1;
		endcase
	end

	// Sense set means jump on a true condition
	assign taken = (ctrl.group == JUMP) && (condTrue == ctrl.sense);
	assign seqPc = pc + PcStep;
	assign target = ctrl.relative ? (seqPc + ctrl.imm) : regValue;
	assign nextPc = taken ? target : seqPc;

endmodule

`default_nettype wire

/* source/busUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module busUnit (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire cpuPkg::phase    curPhase,
	input  wire cpuPkg::ctrlWord ctrl,
	input  wire cpuPkg::dataWord pc,
	input  wire cpuPkg::dataWord addrReg,
	input  wire cpuPkg::dataWord dataReg,
	input  wire cpuPkg::dataWord aluResult,
	input  wire cpuPkg::dataWord din,
	output cpuPkg::dataWord      addr,
	output cpuPkg::dataWord      dout,
	output logic                 rd,
	output logic                 wr,
	output logic                 writeEnable,
	output cpuPkg::dataWord      writeData
);

	import cpuPkg::*;

	logic    isMem;
	logic    memAccess;
	logic    memRead;
	dataWord loadData;

	assign isMem = (ctrl.group == LDST);
	assign memAccess = isMem && (curPhase == EXECUTE);
	assign memRead = memAccess && (ctrl.mem != MEM_ST);

	// PC on the bus except during a data access
	assign addr = memAccess ? addrReg : pc;
	assign dout = dataReg;
	assign rd = (curPhase == FETCH) || memRead;
	assign wr = memAccess && (ctrl.mem == MEM_ST);

	// Memory answers within execute
	always_ff @(posedge clk) begin
		if (rst) begin
			loadData <= '0;
		end else if (memRead) begin
			loadData <= (ctrl.mem == MEM_LDB) ? {8'h00, din[7:0]} : din;
		end
	end

	assign writeEnable = (curPhase == COMMIT) && ctrl.regWrite;
	assign writeData = isMem ? loadData : aluResult;

endmodule

`default_nettype wire

/* source/cpuCore.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuCore #(
	parameter cpuPkg::dataWord PcStep = 16'd2
) (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire cpuPkg::dataWord din,
	output cpuPkg::dataWord      addr,
	output cpuPkg::dataWord      dout,
	output logic                 rd,
	output logic                 wr,
	output logic                 fetch,
	output logic                 decode,
	output logic                 execute,
	output logic                 commit
);

	import cpuPkg::*;

	phase    curPhase;
	dataWord pc;
	dataWord instr;
	dataWord nextPc;
	ctrlWord ctrl;
	dataWord readA;
	dataWord readB;
	dataWord aluResult;
	flagSet  aluFlags;
	logic    writeEnable;
	dataWord writeData;

	// Phase strobes for the outside world
	assign fetch   = (curPhase == FETCH);
	assign decode  = (curPhase == DECODE);
	assign execute = (curPhase == EXECUTE);
	assign commit  = (curPhase == COMMIT);

	phaseSequencer #(.PcStep(PcStep)) i_phaseSequencer (
		.clk      (clk),
		.rst      (rst),
		.din      (din),
		.nextPc   (nextPc),
		.curPhase (curPhase),
		.pc       (pc),
		.instr    (instr)
	);

	instrDecoder i_instrDecoder (
		.instr (instr),
		.ctrl  (ctrl)
	);

	// Port A reads rd, port B reads rs
	regFile i_regFile (
		.clk         (clk),
		.rst         (rst),
		.readIdxA    (ctrl.rd),
		.readIdxB    (ctrl.rs),
		.writeEnable (writeEnable),
		.writeIdx    (ctrl.rd),
		.writeData   (writeData),
		.readA       (readA),
		.readB       (readB)
	);

	aluUnit i_aluUnit (
		.ctrl   (ctrl),
		.opA    (readA),
		.opB    (readB),
		.result (aluResult),
		.flags  (aluFlags)
	);

	branchUnit #(.PcStep(PcStep)) i_branchUnit (
		.clk      (clk),
		.rst      (rst),
		.curPhase (curPhase),
		.ctrl     (ctrl),
		.aluFlags (aluFlags),
		.pc       (pc),
		.regValue (readB),
		.nextPc   (nextPc)
	);

	busUnit i_busUnit (
		.clk         (clk),
		.rst         (rst),
		.curPhase    (curPhase),
		.ctrl        (ctrl),
		.pc          (pc),
		.addrReg     (readB),
		.dataReg     (readA),
		.aluResult   (aluResult),
		.din         (din),
		.addr        (addr),
		.dout        (dout),
		.rd          (rd),
		.wr          (wr),
		.writeEnable (writeEnable),
		.writeData   (writeData)
	);

endmodule

`default_nettype wire

/* bench/coreChecker.sv */
`timescale 1ns/100ps
`default_nettype none

module coreChecker (
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic [15:0] din,
	input  wire logic [15:0] addr,
	input  wire logic [15:0] dout,
	input  wire logic        rd,
	input  wire logic        wr,
	input  wire logic        fetch,
	input  wire logic        decode,
	input  wire logic        execute,
	input  wire logic        commit,
	output int               checkCount,
	output int               errorCount
);

	// Architectural state of the reference model
	logic [15:0] regs [16];
	logic [15:0] pc;
	logic [15:0] instr;
	logic [15:0] loadWord;
	logic        flagZ;
	logic        flagC;
	logic        flagS;
	logic [1:0]  phaseNo;
	int          checks = 0;
	int          errors = 0;

	assign checkCount = checks;
	assign errorCount = errors;

	task automatic expectEq(input string what, input logic [15:0] got, input logic [15:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic expectBus(input logic wantRd, input logic wantWr);
		expectEq("rd strobe", {15'h0000, rd}, {15'h0000, wantRd});
		expectEq("wr strobe", {15'h0000, wr}, {15'h0000, wantWr});
	endtask

	task automatic resetModel();
		int i;
		for (i = 0; i < 16; i++) begin
			regs[i] = 16'h0000;
		end
		pc = 16'h0000;
		flagZ = 1'b0;
		flagC = 1'b0;
		flagS = 1'b0;
		phaseNo = 2'd0;
	endtask

	task automatic execAlu();
		logic [3:0]  dst;
		logic [3:0]  n;
		logic [15:0] opA;
		logic [15:0] opB;
		logic [15:0] res;
		logic        carry;
		dst = instr[7:4];
		opB = regs[instr[3:0]];
		case (instr[9:8])
			2'd1: opB = {12'h000, instr[3:0]};
			2'd2: begin
				dst = 4'd11;
				opB = {8'h00, instr[7:0]};
			end
			2'd3: begin
				// Byte above the low byte of RB
				dst = 4'd10;
				opB = {instr[7:0], regs[11][7:0]};
			end
			default: ;
		endcase
		opA = regs[dst];
		n = opB[3:0];
		carry = 1'b0;
		case (instr[13:10])
			4'd0: res = opB;
			4'd1: begin
				res = opA + opB;
				// Carry out when the sum wraps
				carry = (res < opA);
			end
			4'd2: begin
				res = opA - opB;
				carry = (opA < opB);
			end
			4'd3: res = opA & opB;
			4'd4: res = opA | opB;
			4'd5: res = opA ^ opB;
			4'd6: res = opA << n;
			4'd7: res = opA >> n;
			4'd8: res = (opA >> n) | (opA[15] ? ~(16'hffff >> n) : 16'h0000);
			4'd9: res = (opA >> n) | (opA << (5'd16 - {1'b0, n}));
			// Undefined ops leave registers and flags alone
			default: return;
		endcase
		regs[dst] = res;
		flagZ = (res == 16'h0000);
		flagC = carry;
		flagS = res[15];
	endtask

	task automatic commitInstr();
		logic        condVal;
		logic [15:0] seqPc;
		logic [15:0] target;
		seqPc = pc + 16'd2;
		target = seqPc;
		case (instr[15:14])
			2'b01: execAlu();
			2'b10: begin
				if (instr[13:12] == 2'b00) begin
					regs[instr[7:4]] = loadWord;
				end else if (instr[13:12] == 2'b01) begin
					regs[instr[7:4]] = {8'h00, loadWord[7:0]};
				end
			end
			2'b11: begin
				case (instr[12:11])
					2'd1: condVal = flagZ;
					2'd2: condVal = flagC;
					2'd3: condVal = flagS;
					default: condVal = 1'b1;
				endcase
				if (condVal == instr[13]) begin
					target = instr[8] ? seqPc + {{8{instr[7]}}, instr[7:0]} : regs[instr[3:0]];
				end
			end
			default: ;
		endcase
		// Instructions sit on halfword boundaries
		pc = target & 16'hfffe;
	endtask

	task automatic checkExecute();
		logic isAccess;
		isAccess = (instr[15:14] == 2'b10) && (instr[13:12] != 2'b11);
		if (!isAccess) begin
			expectBus(1'b0, 1'b0);
		end else if (instr[13:12] == 2'b10) begin
			expectBus(1'b0, 1'b1);
			expectEq("store address", addr, regs[instr[3:0]]);
			expectEq("store data", dout, regs[instr[7:4]]);
		end else begin
			expectBus(1'b1, 1'b0);
			expectEq("load address", addr, regs[instr[3:0]]);
			loadWord = din;
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			resetModel();
		end else begin
			expectEq("phase outputs", {12'h000, fetch, decode, execute, commit},
				{12'h000, 4'b1000 >> phaseNo});
			case (phaseNo)
				2'd0: begin
					expectBus(1'b1, 1'b0);
					expectEq("fetch address", addr, pc);
					instr = din;
				end
				2'd1: expectBus(1'b0, 1'b0);
				2'd2: checkExecute();
				default: begin
					expectBus(1'b0, 1'b0);
					commitInstr();
				end
			endcase
			phaseNo = phaseNo + 2'd1;
		end
	end

endmodule

`default_nettype wire

/* bench/tbCore.sv */
`timescale 1ns/100ps
`default_nettype none

module tbCore;

	localparam int numTests = 6;

	logic        clk = 1'b0;
	logic        rst = 1'b1;
	logic [15:0] din = 16'h0000;
	logic [15:0] addr;
	logic [15:0] dout;
	logic        rd;
	logic        wr;
	logic        fetch;
	logic        decode;
	logic        execute;
	logic        commit;
	int          checkCount;
	int          errorCount;

	// Program generator state
	int          seed = 32'hb68d_a040;
	int          testId = 0;
	int          step = 0;
	logic        storeNext = 1'b0;
	logic [3:0]  lastDst = 4'd0;
	logic [15:0] fetchWord;

	always #50 clk = ~clk;

	cpuCore #(.PcStep(16'd2)) i_cpuCore (
		.clk     (clk),
		.rst     (rst),
		.din     (din),
		.addr    (addr),
		.dout    (dout),
		.rd      (rd),
		.wr      (wr),
		.fetch   (fetch),
		.decode  (decode),
		.execute (execute),
		.commit  (commit)
	);

	coreChecker i_coreChecker (
		.clk        (clk),
		.rst        (rst),
		.din        (din),
		.addr       (addr),
		.dout       (dout),
		.rd         (rd),
		.wr         (wr),
		.fetch      (fetch),
		.decode     (decode),
		.execute    (execute),
		.commit     (commit),
		.checkCount (checkCount),
		.errorCount (errorCount)
	);

	function automatic logic [15:0] randWord();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	function automatic int lengthOf(input int t);
		case (t)
			0: return 8;
			1: return 120;
			2: return 120;
			3: return 80;
			4: return 150;
			default: return 600;
		endcase
	endfunction

	function automatic string testName(input int t);
		case (t)
			0: return "reset";
			1: return "ALU register ops";
			2: return "immediate modes";
			3: return "loads";
			4: return "jumps";
			default: return "mixed run";
		endcase
	endfunction

	// Next instruction word for the running test
	task automatic makeInstr(output logic [15:0] word);
		logic [15:0] r;
		logic [15:0] opPick;
		logic [15:0] modePick;
		logic [1:0]  mode;
		r = randWord();
		opPick = randWord() % 16'd10;
		modePick = randWord() % 16'd3;
		mode = (testId == 2) ? modePick[1:0] + 2'd1 : 2'd0;
		word = {2'b00, r[13:0]};
		case (testId)
			1, 2, 3: begin
				if (storeNext) begin
					word = {4'b1010, 4'h0, lastDst, r[3:0]};
				end else if (testId == 3 || (testId == 1 && r[15:14] == 2'b00)) begin
					// LD or LDB
					// Test 1 also loads random words so the ALU operands are not all zero
					word = {3'b100, r[12], 4'h0, r[7:4], r[3:0]};
					lastDst = r[7:4];
				end else begin
					word = {2'b01, opPick[3:0], mode, r[7:0]};
					lastDst = (mode == 2'd2) ? 4'd11 : (mode == 2'd3) ? 4'd10 : r[7:4];
				end
				storeNext = ~storeNext;
			end
			4: begin
				// Flag setter, then a jump, then a NOP
				if (step % 3 == 0) begin
					word = {2'b01, opPick[3:0], 2'b00, r[7:0]};
				end else if (step % 3 == 1) begin
					word = {2'b11, r[13:0]};
				end
			end
			5: word = r;
			default: ;
		endcase
		step++;
	endtask

	// Memory responder
	always @(posedge clk) begin
		#5;
		if (fetch && rd) begin
			makeInstr(fetchWord);
			din = fetchWord;
		end else if (rd) begin
			din = randWord();
		end else begin
			din = 16'h0000;
		end
	end

	task automatic waitCommit();
		do begin
			@(negedge clk);
		end while (!commit);
	endtask

	initial begin : mainFlow
		int t;
		int chkBefore;
		int errBefore;
		repeat (8) @(posedge clk);
		#5;
		rst = 1'b0;
		for (t = 0; t < numTests; t++) begin
			testId = t;
			chkBefore = checkCount;
			errBefore = errorCount;
			repeat (lengthOf(t)) waitCommit();
			@(posedge clk);
			#1;
			$display("Test %0d (%s): %0d checks, %0d errors", t, testName(t),
				checkCount - chkBefore, errorCount - errBefore);
		end
		$display("Totals: %0d tests, %0d checks, %0d errors", numTests, checkCount, errorCount);
		if (errorCount == 0 && checkCount > 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Four cycles per instruction plus reset and some slack
	initial begin : watchdog
		int t;
		int limit;
		limit = 0;
		for (t = 0; t < numTests; t++) begin
			limit += lengthOf(t);
		end
		limit = (limit * 4 + 8 + 50) * 100;
		#(limit);
		$display("Run timed out after %0d ns before all tests finished", limit);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
source/cpuPkg.sv
source/phaseSequencer.sv
source/instrDecoder.sv
source/regFile.sv
source/aluUnit.sv
source/branchUnit.sv
source/busUnit.sv
source/cpuCore.sv
bench/coreChecker.sv
bench/tbCore.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f project.f --top-module tbCore -o simCore
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simCore > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Regression passed" sim.log; then
	exit 0
fi
exit 1
